// ==== source/quant_functions.svh ====
`ifndef QUANT_FUNCTIONS_SVH
`define QUANT_FUNCTIONS_SVH

// saturate to the signed 8-bit range
function automatic cnn_data_pkg::pixel_t clamp(input cnn_data_pkg::acc_t v);
    if (v > 127)
        return 8'sh7f;
    else if (v < -128)
        return 8'sh80;
    return cnn_data_pkg::pixel_t'(v);
endfunction

`endif

// ==== source/cnn_geom_pkg.sv ====
`default_nettype none

package cnn_geom_pkg;

    // input image and every feature map are square
    localparam int IMG_W = 28;
    localparam int IMG_PIX = IMG_W * IMG_W;

    localparam int N_CH = 8;

    // 3x3 kernel, taps numbered row by row
    localparam int K_W = 3;
    localparam int K_TAPS = K_W * K_W;

    localparam int POOL_OUT_W = IMG_W / 2;
    localparam int POOL_PIX = POOL_OUT_W * POOL_OUT_W;

    // dot product scaling before the bias is added
    localparam int ACC_SHIFT = 4;

endpackage

`default_nettype wire

// ==== source/cnn_data_pkg.sv ====
`default_nettype none

package cnn_data_pkg;

    // pixels, weights and biases share one format
    typedef logic signed [7:0] pixel_t;

    // nine 16-bit products fit without overflow
    typedef logic signed [19:0] acc_t;

    typedef logic [9:0] addr_t;
    typedef logic [2:0] chan_t;
    typedef logic [3:0] tap_t;

    typedef enum logic [2:0] {
        IDLE,
        CONV_ISSUE,
        CONV_WAIT,
        POOL,
        DONE
    } ctrl_state_e;

endpackage

`default_nettype wire

// ==== source/conv_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_engine
(
    input  wire                                   clk,
    input  wire                                   rst,
    input  wire                                   img_we,
    input  wire cnn_data_pkg::addr_t              img_addr,
    input  wire cnn_data_pkg::pixel_t             img_data,
    input  wire                                   wgt_we,
    input  wire [6:0]                             wgt_addr,
    input  wire cnn_data_pkg::pixel_t             wgt_data,
    input  wire                                   bias_we,
    input  wire cnn_data_pkg::chan_t              bias_chan,
    input  wire cnn_data_pkg::pixel_t             bias_data,
    input  wire                                   mac_start,
    input  wire [$clog2(cnn_geom_pkg::IMG_W)-1:0] pix_row,
    input  wire [$clog2(cnn_geom_pkg::IMG_W)-1:0] pix_col,
    input  wire cnn_data_pkg::chan_t              chan,
    output logic                                  mac_valid,
    output cnn_data_pkg::acc_t                    mac_sum,
    output cnn_data_pkg::pixel_t                  store_bias
);
    import cnn_geom_pkg::*;
    import cnn_data_pkg::*;

    pixel_t img_mem [IMG_PIX];
    pixel_t wgt_mem [N_CH * K_TAPS];
    pixel_t bias_mem [N_CH];

    logic [$clog2(IMG_W)-1:0] row_q;
    logic [$clog2(IMG_W)-1:0] col_q;
    chan_t                    chan_q;
    tap_t                     tap_q;
    logic                     issuing;

    logic [$clog2(IMG_W)-1:0] row_s;
    logic [$clog2(IMG_W)-1:0] col_s;
    chan_t                    chan_s;
    tap_t                     tap_s;
    logic                     issue;

    int                       nr;
    int                       nc;
    logic                     in_img;
    addr_t                    img_raddr;
    logic [6:0]               wgt_raddr;

    pixel_t                   img_rd;
    pixel_t                   wgt_rd;
    logic                     pad_q;
    logic                     prod_vld;
    logic                     prod_last;
    acc_t                     prod;
    acc_t                     acc;
    logic                     sum_go;

    // tap 0 goes out in the mac_start cycle straight from the ports
    always_comb
    begin
        row_s  = mac_start ? pix_row : row_q;
        col_s  = mac_start ? pix_col : col_q;
        chan_s = mac_start ? chan : chan_q;
        tap_s  = mac_start ? '0 : tap_q;
        issue  = mac_start || issuing;
    end

    // neighbor of the output pixel, kernel centered on it
    always_comb
    begin
        nr = int'(row_s) + int'(tap_s) / K_W - 1;
        nc = int'(col_s) + int'(tap_s) % K_W - 1;
        in_img = (nr >= 0) && (nr < IMG_W) && (nc >= 0) && (nc < IMG_W);
        img_raddr = in_img ? addr_t'(nr * IMG_W + nc) : '0;
        wgt_raddr = 7'(int'(chan_s) * K_TAPS + int'(tap_s));
    end

    // host load ports
    always_ff @(posedge clk)
    begin
        if (img_we)
            img_mem[img_addr] <= img_data;
        if (wgt_we)
            wgt_mem[wgt_addr] <= wgt_data;
        if (bias_we)
            bias_mem[bias_chan] <= bias_data;
    end

    always_ff @(posedge clk)
    begin
        img_rd <= img_mem[img_raddr];
        wgt_rd <= wgt_mem[wgt_raddr];
        pad_q  <= !in_img;
        if (mac_start)
        begin
            row_q  <= pix_row;
            col_q  <= pix_col;
            chan_q <= chan;
        end
    end

    // padded taps count as zero
    always_comb
    begin
        prod = img_rd * wgt_rd;
        if (pad_q)
            prod = '0;
    end

    always_ff @(posedge clk)
    begin
        if (mac_start)
            acc <= '0;
        else if (prod_vld)
            acc <= acc + prod;
        if (sum_go)
        begin
            mac_sum    <= acc >>> ACC_SHIFT;
            store_bias <= bias_mem[chan_q];
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            tap_q     <= '0;
            issuing   <= 1'b0;
            prod_vld  <= 1'b0;
            prod_last <= 1'b0;
            sum_go    <= 1'b0;
            mac_valid <= 1'b0;
        end
        else
        begin
            if (issue)
            begin
                tap_q   <= tap_s + 1'b1;
                issuing <= (tap_s != tap_t'(K_TAPS - 1));
            end
            prod_vld  <= issue;
            prod_last <= issue && (tap_s == tap_t'(K_TAPS - 1));
            sum_go    <= prod_last;
            mac_valid <= sum_go;
        end
    end

    // the controller waits for each result before the next pixel
    assert property (@(posedge clk) disable iff (!rst)
        mac_start |-> !(issuing || prod_vld || sum_go));

endmodule

`default_nettype wire

// ==== source/feature_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module feature_bank
(
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        store,
    input  wire cnn_data_pkg::chan_t   store_chan,
    input  wire cnn_data_pkg::addr_t   store_addr,
    input  wire cnn_data_pkg::pixel_t  store_bias,
    input  wire cnn_data_pkg::acc_t    value,
    input  wire                        pool,
    input  wire                        rd_en,
    input  wire cnn_data_pkg::chan_t   rd_chan,
    input  wire cnn_data_pkg::addr_t   rd_addr1,
    input  wire cnn_data_pkg::addr_t   rd_addr2,
    output logic                       pool_done,
    output cnn_data_pkg::pixel_t       rd_data1,
    output cnn_data_pkg::pixel_t       rd_data2
);
    import cnn_geom_pkg::*;
    import cnn_data_pkg::*;

    `include "quant_functions.svh"

    // one block-RAM bank per output channel
    pixel_t fmap [N_CH][IMG_PIX];

    // top-left corner of the current pooling window
    addr_t      pool_addr;
    logic [3:0] pool_col;
    logic [7:0] pool_win;
    logic       pool_active;

    // largest of four, negative results become zero
    function automatic pixel_t relu_max4(
        input pixel_t a,
        input pixel_t b,
        input pixel_t c,
        input pixel_t d
    );
        pixel_t m;
        m = a;
        if (b > m)
            m = b;
        if (c > m)
            m = c;
        if (d > m)
            m = d;
        return (m > 0) ? m : '0;
    endfunction

    assign pool_active = pool && !pool_done;

    // stores and pooled values share the write port
    always_ff @(posedge clk)
    begin
        if (store)
        begin
            fmap[store_chan][store_addr] <= clamp(value + store_bias);
        end
        else if (pool_active)
        begin
            for (int c = 0; c < N_CH; c++)
            begin
                fmap[c][pool_addr] <= relu_max4(
                    fmap[c][pool_addr],
                    fmap[c][pool_addr + 1],
                    fmap[c][pool_addr + IMG_W],
                    fmap[c][pool_addr + IMG_W + 1]
                );
            end
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            pool_addr <= '0;
            pool_col  <= '0;
            pool_win  <= '0;
            pool_done <= 1'b0;
            rd_data1  <= '0;
            rd_data2  <= '0;
        end
        else
        begin
            if (pool_active)
            begin
                if (pool_win == 8'(POOL_PIX - 1))
                begin
                    pool_done <= 1'b1;
                    pool_win  <= '0;
                    pool_col  <= '0;
                    pool_addr <= '0;
                end
                else
                begin
                    pool_win <= pool_win + 1'b1;
                    // end of a window row skips the odd image row
                    if (pool_col == 4'(POOL_OUT_W - 1))
                    begin
                        pool_col  <= '0;
                        pool_addr <= pool_addr + addr_t'(IMG_W + 2);
                    end
                    else
                    begin
                        pool_col  <= pool_col + 1'b1;
                        pool_addr <= pool_addr + 2'd2;
                    end
                end
            end
            else if (!pool)
            begin
                pool_done <= 1'b0;
            end

            if (rd_en)
            begin
                rd_data1 <= fmap[rd_chan][rd_addr1];
                rd_data2 <= fmap[rd_chan][rd_addr2];
            end
        end
    end

    // the controller finishes all stores before pooling
    assert property (@(posedge clk) disable iff (!rst)
        !(store && pool));

    assert property (@(posedge clk) disable iff (!rst)
        rd_en |-> (rd_addr1 < IMG_PIX) && (rd_addr2 < IMG_PIX));

endmodule

`default_nettype wire

// ==== source/layer1_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module layer1_ctrl
(
    input  wire                                    clk,
    input  wire                                    rst,
    input  wire                                    start,
    input  wire                                    pool_en,
    input  wire                                    mac_valid,
    input  wire                                    pool_done,
    output logic                                   busy,
    output logic                                   done,
    output logic                                   mac_start,
    output logic [$clog2(cnn_geom_pkg::IMG_W)-1:0] pix_row,
    output logic [$clog2(cnn_geom_pkg::IMG_W)-1:0] pix_col,
    output cnn_data_pkg::chan_t                    chan,
    output logic                                   store,
    output cnn_data_pkg::chan_t                    store_chan,
    output cnn_data_pkg::addr_t                    store_addr,
    output logic                                   pool
);
    import cnn_geom_pkg::*;
    import cnn_data_pkg::*;

    ctrl_state_e state;
    logic        pool_en_q;
    logic        last_col;
    logic        last_row;
    logic        last_chan;

    assign busy      = (state != IDLE);
    assign done      = (state == DONE);
    assign mac_start = (state == CONV_ISSUE);
    assign pool      = (state == POOL);

    // result belongs to the pixel the counters still point at
    assign store      = (state == CONV_WAIT) && mac_valid;
    assign store_chan = chan;
    assign store_addr = addr_t'(pix_row * IMG_W + pix_col);

    assign last_col  = (pix_col == IMG_W - 1);
    assign last_row  = (pix_row == IMG_W - 1);
    assign last_chan = (chan == N_CH - 1);

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state     <= IDLE;
            pool_en_q <= 1'b0;
            pix_row   <= '0;
            pix_col   <= '0;
            chan      <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                    if (start)
                    begin
                        pool_en_q <= pool_en;
                        pix_row   <= '0;
                        pix_col   <= '0;
                        chan      <= '0;
                        state     <= CONV_ISSUE;
                    end
                CONV_ISSUE:
                    state <= CONV_WAIT;
                CONV_WAIT:
                    if (mac_valid)
                    begin
                        pix_col <= last_col ? '0 : pix_col + 1'b1;
                        if (last_col)
                        begin
                            pix_row <= last_row ? '0 : pix_row + 1'b1;
                            if (last_row)
                                chan <= chan + 1'b1;
                        end
                        if (last_col && last_row && last_chan)
                            state <= pool_en_q ? POOL : DONE;
                        else
                            state <= CONV_ISSUE;
                    end
                POOL:
                    if (pool_done)
                        state <= DONE;
                DONE:
                    state <= IDLE;
                default:
                    state <= IDLE;
            endcase
        end
    end

    // engine results only arrive for an issued pixel
    assert property (@(posedge clk) disable iff (!rst)
        mac_valid |-> (state == CONV_WAIT));

endmodule

`default_nettype wire

// ==== source/layer1_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module layer1_top
(
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       img_we,
    input  wire cnn_data_pkg::addr_t  img_addr,
    input  wire cnn_data_pkg::pixel_t img_data,
    input  wire                       wgt_we,
    input  wire [6:0]                 wgt_addr,
    input  wire cnn_data_pkg::pixel_t wgt_data,
    input  wire                       bias_we,
    input  wire cnn_data_pkg::chan_t  bias_chan,
    input  wire cnn_data_pkg::pixel_t bias_data,
    input  wire                       start,
    input  wire                       pool_en,
    input  wire                       rd_en,
    input  wire cnn_data_pkg::chan_t  rd_chan,
    input  wire cnn_data_pkg::addr_t  rd_addr1,
    input  wire cnn_data_pkg::addr_t  rd_addr2,
    output logic                      busy,
    output logic                      done,
    output cnn_data_pkg::pixel_t      rd_data1,
    output cnn_data_pkg::pixel_t      rd_data2
);
    import cnn_geom_pkg::*;
    import cnn_data_pkg::*;

    logic                     mac_start;
    logic [$clog2(IMG_W)-1:0] pix_row;
    logic [$clog2(IMG_W)-1:0] pix_col;
    chan_t                    chan;
    logic                     mac_valid;
    acc_t                     mac_sum;
    pixel_t                   store_bias;
    logic                     store;
    chan_t                    store_chan;
    addr_t                    store_addr;
    logic                     pool;
    logic                     pool_done;

    layer1_ctrl layer1_ctrl_inst (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .pool_en    (pool_en),
        .mac_valid  (mac_valid),
        .pool_done  (pool_done),
        .busy       (busy),
        .done       (done),
        .mac_start  (mac_start),
        .pix_row    (pix_row),
        .pix_col    (pix_col),
        .chan       (chan),
        .store      (store),
        .store_chan (store_chan),
        .store_addr (store_addr),
        .pool       (pool)
    );

    conv_engine conv_engine_inst (
        .clk        (clk),
        .rst        (rst),
        .img_we     (img_we),
        .img_addr   (img_addr),
        .img_data   (img_data),
        .wgt_we     (wgt_we),
        .wgt_addr   (wgt_addr),
        .wgt_data   (wgt_data),
        .bias_we    (bias_we),
        .bias_chan  (bias_chan),
        .bias_data  (bias_data),
        .mac_start  (mac_start),
        .pix_row    (pix_row),
        .pix_col    (pix_col),
        .chan       (chan),
        .mac_valid  (mac_valid),
        .mac_sum    (mac_sum),
        .store_bias (store_bias)
    );

    feature_bank feature_bank_inst (
        .clk        (clk),
        .rst        (rst),
        .store      (store),
        .store_chan (store_chan),
        .store_addr (store_addr),
        .store_bias (store_bias),
        .value      (mac_sum),
        .pool       (pool),
        .rd_en      (rd_en),
        .rd_chan    (rd_chan),
        .rd_addr1   (rd_addr1),
        .rd_addr2   (rd_addr2),
        .pool_done  (pool_done),
        .rd_data1   (rd_data1),
        .rd_data2   (rd_data2)
    );

endmodule

`default_nettype wire

// ==== bench/layer1_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module layer1_tb;
    import cnn_geom_pkg::*;
    import cnn_data_pkg::*;

    // one issue cycle plus eleven engine cycles per output pixel
    localparam int PIX_CYCLES = 12;
    localparam int CONV_CYCLES = N_CH * IMG_PIX * PIX_CYCLES;
    localparam int LOAD_CYCLES = IMG_PIX + N_CH * K_TAPS + N_CH + 3;
    localparam int READ_CYCLES = N_CH * IMG_PIX + 100;
    localparam int TEST_CYCLES = LOAD_CYCLES + CONV_CYCLES + POOL_PIX + READ_CYCLES + 100;
    localparam int N_TESTS = 6;
    localparam int CYCLE_LIMIT = N_TESTS * TEST_CYCLES + 20;

    logic       clk = 1'b0;
    logic       rst;
    logic       img_we;
    addr_t      img_addr;
    pixel_t     img_data;
    logic       wgt_we;
    logic [6:0] wgt_addr;
    pixel_t     wgt_data;
    logic       bias_we;
    chan_t      bias_chan;
    pixel_t     bias_data;
    logic       start;
    logic       pool_en;
    logic       rd_en;
    chan_t      rd_chan;
    addr_t      rd_addr1;
    addr_t      rd_addr2;
    logic       busy;
    logic       done;
    pixel_t     rd_data1;
    pixel_t     rd_data2;

    // reference copies of the host data and the expected maps
    pixel_t m_img [IMG_PIX];
    pixel_t m_wgt [N_CH * K_TAPS];
    pixel_t m_bias [N_CH];
    pixel_t exp_map [N_CH][IMG_PIX];

    logic [31:0] lfsr = 32'hd7aa;
    int cycles = 0;
    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;

    layer1_top layer1_top_inst (
        .clk       (clk),
        .rst       (rst),
        .img_we    (img_we),
        .img_addr  (img_addr),
        .img_data  (img_data),
        .wgt_we    (wgt_we),
        .wgt_addr  (wgt_addr),
        .wgt_data  (wgt_data),
        .bias_we   (bias_we),
        .bias_chan (bias_chan),
        .bias_data (bias_data),
        .start     (start),
        .pool_en   (pool_en),
        .rd_en     (rd_en),
        .rd_chan   (rd_chan),
        .rd_addr1  (rd_addr1),
        .rd_addr2  (rd_addr2),
        .busy      (busy),
        .done      (done),
        .rd_data1  (rd_data1),
        .rd_data2  (rd_data2)
    );

    always #10 clk = ~clk;

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("timeout after %0d cycles, the DUT never finished", cycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // taps 32, 22, 2, 1
    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    function automatic pixel_t saturate8(input int v);
        if (v > 127)
            return pixel_t'(127);
        else if (v < -128)
            return pixel_t'(-128);
        return pixel_t'(v);
    endfunction

    function automatic int window_addr(input int w);
        return (w / POOL_OUT_W) * 2 * IMG_W + (w % POOL_OUT_W) * 2;
    endfunction

    task automatic check_pixel(input string test, input int ch, input int addr,
                               input pixel_t exp, input pixel_t act);
        if (act !== exp)
        begin
            errors++;
            $display("error: %s ch %0d addr %0d expected %0d actual %0d",
                     test, ch, addr, exp, act);
        end
    endtask

    task automatic check_flag(input string test, input string what,
                              input logic exp, input logic act);
        if (act !== exp)
        begin
            errors++;
            $display("error: %s %s expected %b actual %b", test, what, exp, act);
        end
    endtask

    task automatic check_count(input string test, input string what,
                               input int exp, input int act);
        if (act != exp)
        begin
            errors++;
            $display("error: %s %s expected %0d actual %0d", test, what, exp, act);
        end
    endtask

    task automatic finish_test(input string test, input int err0);
        tests_run++;
        if (errors != err0)
        begin
            tests_failed++;
            $display("test %s: failed with %0d errors", test, errors - err0);
        end
        else
            $display("test %s: ok", test);
    endtask

    // zero padding, shift, bias and clamp, then optional max pool with relu
    task automatic build_model(input bit with_pool);
        int sum;
        int nr;
        int nc;
        int a;
        pixel_t m;
        for (int c = 0; c < N_CH; c++)
            for (int r = 0; r < IMG_W; r++)
                for (int col = 0; col < IMG_W; col++)
                begin
                    sum = 0;
                    for (int t = 0; t < K_TAPS; t++)
                    begin
                        nr = r + t / 3 - 1;
                        nc = col + t % 3 - 1;
                        if (nr >= 0 && nr < IMG_W && nc >= 0 && nc < IMG_W)
                            sum += int'(m_img[nr * IMG_W + nc]) * int'(m_wgt[c * K_TAPS + t]);
                    end
                    exp_map[c][r * IMG_W + col] = saturate8((sum >>> ACC_SHIFT) + int'(m_bias[c]));
                end
        if (with_pool)
            for (int c = 0; c < N_CH; c++)
                for (int w = 0; w < POOL_PIX; w++)
                begin
                    a = window_addr(w);
                    m = exp_map[c][a];
                    if (exp_map[c][a + 1] > m)
                        m = exp_map[c][a + 1];
                    if (exp_map[c][a + IMG_W] > m)
                        m = exp_map[c][a + IMG_W];
                    if (exp_map[c][a + IMG_W + 1] > m)
                        m = exp_map[c][a + IMG_W + 1];
                    exp_map[c][a] = (m > 0) ? m : pixel_t'(0);
                end
    endtask

    task automatic fill_random;
        for (int i = 0; i < IMG_PIX; i++)
            m_img[i] = pixel_t'(rand_bits(8));
        // small weights keep most sums inside the clamp range
        for (int i = 0; i < N_CH * K_TAPS; i++)
            m_wgt[i] = pixel_t'(rand_bits(4) - 8);
        for (int c = 0; c < N_CH; c++)
            m_bias[c] = pixel_t'(rand_bits(8));
    endtask

    task automatic load_dut;
        for (int i = 0; i < IMG_PIX; i++)
        begin
            @(posedge clk);
            img_we   <= 1'b1;
            img_addr <= addr_t'(i);
            img_data <= m_img[i];
        end
        @(posedge clk);
        img_we <= 1'b0;
        for (int i = 0; i < N_CH * K_TAPS; i++)
        begin
            @(posedge clk);
            wgt_we   <= 1'b1;
            wgt_addr <= 7'(i);
            wgt_data <= m_wgt[i];
        end
        @(posedge clk);
        wgt_we <= 1'b0;
        for (int c = 0; c < N_CH; c++)
        begin
            @(posedge clk);
            bias_we   <= 1'b1;
            bias_chan <= chan_t'(c);
            bias_data <= m_bias[c];
        end
        @(posedge clk);
        bias_we <= 1'b0;
    endtask

    task automatic launch(input bit pe);
        @(posedge clk);
        start   <= 1'b1;
        pool_en <= pe;
        @(posedge clk);
        start   <= 1'b0;
        pool_en <= 1'b0;
    endtask

    // counts the cycles that are busy but not yet done
    task automatic wait_done(input string test, output int n_busy);
        bit seen;
        bit dropped;
        seen = 1'b0;
        dropped = 1'b0;
        n_busy = 0;
        while (!seen)
        begin
            @(negedge clk);
            if (done)
                seen = 1'b1;
            else if (busy)
                n_busy++;
            else
                dropped = 1'b1;
        end
        check_flag(test, "busy at done", 1'b1, busy);
        check_flag(test, "busy dropped before done", 1'b0, dropped);
    endtask

    task automatic watch_idle(input string test, input int n);
        int extra_done;
        bit busy_seen;
        extra_done = 0;
        busy_seen = 1'b0;
        repeat (n)
        begin
            @(negedge clk);
            if (done)
                extra_done++;
            if (busy)
                busy_seen = 1'b1;
        end
        check_count(test, "done cycles after the pulse", 0, extra_done);
        check_flag(test, "busy after done", 1'b0, busy_seen);
    endtask

    task automatic read_pair(input chan_t ch, input addr_t a1, input addr_t a2,
                             output pixel_t d1, output pixel_t d2);
        @(posedge clk);
        rd_en    <= 1'b1;
        rd_chan  <= ch;
        rd_addr1 <= a1;
        rd_addr2 <= a2;
        @(posedge clk);
        rd_en <= 1'b0;
        @(negedge clk);
        d1 = rd_data1;
        d2 = rd_data2;
    endtask

    // pairs each address with its mirror so both ports see every location
    task automatic check_map(input string test);
        pixel_t d1;
        pixel_t d2;
        int a2;
        for (int c = 0; c < N_CH; c++)
            for (int k = 0; k < IMG_PIX / 2; k++)
            begin
                a2 = IMG_PIX - 1 - k;
                read_pair(chan_t'(c), addr_t'(k), addr_t'(a2), d1, d2);
                check_pixel(test, c, k, exp_map[c][k], d1);
                check_pixel(test, c, a2, exp_map[c][a2], d2);
            end
    endtask

    task automatic check_pooled(input string test, input bit expect_zero);
        pixel_t d1;
        pixel_t d2;
        int a1;
        int a2;
        for (int c = 0; c < N_CH; c++)
            for (int w = 0; w < POOL_PIX / 2; w++)
            begin
                a1 = window_addr(w);
                a2 = window_addr(POOL_PIX - 1 - w);
                read_pair(chan_t'(c), addr_t'(a1), addr_t'(a2), d1, d2);
                check_pixel(test, c, a1, expect_zero ? pixel_t'(0) : exp_map[c][a1], d1);
                check_pixel(test, c, a2, expect_zero ? pixel_t'(0) : exp_map[c][a2], d2);
            end
    endtask

    task automatic test_reset_idle;
        int err0;
        int n_busy;
        err0 = errors;
        @(negedge clk);
        check_flag("reset_idle", "busy", 1'b0, busy);
        check_flag("reset_idle", "done", 1'b0, done);
        check_pixel("reset_idle", 0, 0, pixel_t'(0), rd_data1);
        check_pixel("reset_idle", 0, 0, pixel_t'(0), rd_data2);
        launch(1'b0);
        wait_done("reset_idle", n_busy);
        check_count("reset_idle", "run cycles", CONV_CYCLES, n_busy);
        watch_idle("reset_idle", 20);
        finish_test("reset_idle", err0);
    endtask

    task automatic test_random_nopool;
        int err0;
        int n_busy;
        err0 = errors;
        fill_random();
        build_model(1'b0);
        load_dut();
        launch(1'b0);
        wait_done("random_nopool", n_busy);
        check_map("random_nopool");
        finish_test("random_nopool", err0);
    endtask

    task automatic test_saturation;
        int err0;
        int n_busy;
        err0 = errors;
        for (int i = 0; i < IMG_PIX; i++)
            m_img[i] = pixel_t'(rand_bits(8));
        for (int i = 0; i < N_CH * K_TAPS; i++)
            m_wgt[i] = rand_bits(1) ? pixel_t'(127) : pixel_t'(-128);
        for (int c = 0; c < N_CH; c++)
            m_bias[c] = rand_bits(1) ? pixel_t'(127) : pixel_t'(-128);
        build_model(1'b0);
        load_dut();
        launch(1'b0);
        wait_done("saturation", n_busy);
        check_map("saturation");
        finish_test("saturation", err0);
    endtask

    task automatic test_random_pool;
        int err0;
        int n_busy;
        err0 = errors;
        fill_random();
        build_model(1'b1);
        load_dut();
        launch(1'b1);
        wait_done("random_pool", n_busy);
        check_count("random_pool", "run cycles", CONV_CYCLES + POOL_PIX + 1, n_busy);
        check_pooled("random_pool", 1'b0);
        finish_test("random_pool", err0);
    endtask

    // positive image, negative weights and biases give a negative map
    task automatic test_negative_pool;
        int err0;
        int n_busy;
        err0 = errors;
        for (int i = 0; i < IMG_PIX; i++)
            m_img[i] = pixel_t'(1 + rand_bits(6));
        for (int i = 0; i < N_CH * K_TAPS; i++)
            m_wgt[i] = pixel_t'(-1 - rand_bits(6));
        for (int c = 0; c < N_CH; c++)
            m_bias[c] = pixel_t'(-rand_bits(6));
        build_model(1'b1);
        load_dut();
        launch(1'b1);
        wait_done("negative_pool", n_busy);
        check_pooled("negative_pool", 1'b1);
        finish_test("negative_pool", err0);
    endtask

    task automatic test_start_while_busy;
        int err0;
        int n_busy;
        err0 = errors;
        fill_random();
        build_model(1'b0);
        load_dut();
        launch(1'b0);
        repeat (50) @(posedge clk);
        start   <= 1'b1;
        pool_en <= 1'b1;
        @(posedge clk);
        start   <= 1'b0;
        pool_en <= 1'b0;
        wait_done("start_while_busy", n_busy);
        watch_idle("start_while_busy", 40);
        check_map("start_while_busy");
        finish_test("start_while_busy", err0);
    endtask

    initial
    begin
        rst       <= 1'b0;
        img_we    <= 1'b0;
        img_addr  <= '0;
        img_data  <= '0;
        wgt_we    <= 1'b0;
        wgt_addr  <= '0;
        wgt_data  <= '0;
        bias_we   <= 1'b0;
        bias_chan <= '0;
        bias_data <= '0;
        start     <= 1'b0;
        pool_en   <= 1'b0;
        rd_en     <= 1'b0;
        rd_chan   <= '0;
        rd_addr1  <= '0;
        rd_addr2  <= '0;
        repeat (10) @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);

        test_reset_idle();
        test_random_nopool();
        test_saturation();
        test_random_pool();
        test_negative_pool();
        test_start_while_busy();

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+source
source/cnn_geom_pkg.sv
source/cnn_data_pkg.sv
source/conv_engine.sv
source/feature_bank.sv
source/layer1_ctrl.sv
source/layer1_top.sv
bench/layer1_tb.sv

// ==== Bender.yml ====
package:
  name: cnn_layer1

export_include_dirs:
  - source

sources:
  - source/cnn_geom_pkg.sv
  - source/cnn_data_pkg.sv
  - source/conv_engine.sv
  - source/feature_bank.sv
  - source/layer1_ctrl.sv
  - source/layer1_top.sv
  - target: simulation
    files:
      - bench/layer1_tb.sv
